// File: vlog.f
verilog/fp2Pkg.sv
verilog/fp2ElemIf.sv
verilog/fp2Unpack.sv
verilog/fp2Normalize.sv
verilog/fp2Pack.sv
verilog/fp2Convert.sv
test/fp2Convert_assert.sv
test/fp2ConvertCheck.sv
test/fp2ConvertTb.sv

// File: Makefile
# Verilator build and run of the converter testbench.

SIM := obj_dir/Vfp2ConvertTb
SRC := $(shell cat vlog.f)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module fp2ConvertTb -f vlog.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: test/fp2ConvertTb.sv
/*
 Random stimulus for the element converter from a fixed seed.
 Inputs change on the falling clock edge. The run ends by timeout if results stop coming.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2ConvertTb;
	import fp2Pkg::*;

	localparam int stimCycles    = 4000;
	localparam int timeoutCycles = stimCycles + 20;

	logic   clock;
	logic   arstN;
	logic   inValid;
	vecT    vecData;
	posT    vecPos;
	fmtT    dstFmt;
	logic   outValid;
	elemT   outData;
	logic   done;
	int     valueErrors;
	int     flowErrors;
	int     pending;
	int     cycleCount;
	integer seed;

	fp2Convert DUT (
		.clock    (clock),
		.arstN    (arstN),
		.inValid  (inValid),
		.vecData  (vecData),
		.vecPos   (vecPos),
		.dstFmt   (dstFmt),
		.outValid (outValid),
		.outData  (outData)
	);

	fp2ConvertCheck uCheck (
		.clock       (clock),
		.arstN       (arstN),
		.inValid     (inValid),
		.vecData     (vecData),
		.vecPos      (vecPos),
		.dstFmt      (dstFmt),
		.outValid    (outValid),
		.outData     (outData),
		.done        (done),
		.valueErrors (valueErrors),
		.flowErrors  (flowErrors),
		.pending     (pending)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		if (arstN)
			cycleCount++; // Counts from reset release.
		if (cycleCount > timeoutCycles) begin
			$display("Timeout after %0d cycles, %0d results still pending", cycleCount, pending);
			$display("Finished with errors");
			$finish;
		end
	end

	// One cycle of stimulus. The selected lane is often forced to an edge case.
	task automatic driveStimulus();
		logic [2:0]  flavor;
		logic [63:0] lane;
		logic [63:0] mask;
		logic [63:0] field;
		int          w;
		int          eb;
		int          fb;
		int          dEb;
		int          u;
		int          shift;

		inValid   = ({$random(seed)} % 10) < 7;
		vecData   = {$random(seed), $random(seed), $random(seed), $random(seed)};
		vecPos    = posT'($random(seed));
		vecPos[5] = ({$random(seed)} % 4) == 0;
		dstFmt    = fmtT'($random(seed));
		flavor    = 3'($random(seed));
		w     = (vecPos[3:2] == 2'd3) ? 64 : 16 << vecPos[3:2];
		mask  = {64{1'b1}} >> (64 - w);
		lane  = {$random(seed), $random(seed)} & mask;
		eb    = (w == 16) ? 5 : (w == 32) ? 8 : 11;
		fb    = w - 1 - eb;
		field = (64'd1 << eb) - 1; // Exponent field mask.
		dEb   = (dstFmt == fmtBin16) ? 5 : (dstFmt == fmtBin32) ? 8 : 11;
		if (!vecPos[4] && !vecPos[5]) begin
			case (flavor)
				3'd3: begin // Near the largest or smallest normal of the target.
					u = (($random(seed) & 1) != 0) ? (1 << (dEb - 1)) - 1 : 2 - (1 << (dEb - 1));
					u = u + int'({$random(seed)} % 5) - 2 + (1 << (eb - 1)) - 1;
					lane = (lane & ~(field << fb)) | ((64'(u) & field) << fb);
				end
				3'd4: begin
					lane = lane | (field << fb); // Inf or NaN.
					if (($random(seed) & 1) != 0)
						lane = lane & ~(mask >> (eb + 1));
				end
				3'd5: lane = lane & ~(field << fb); // Zero or subnormal.
				3'd6: lane = lane | (mask >> (eb + 1)); // Rounds up into the exponent.
				3'd7: begin
					u = (dstFmt == fmtBin16) ? 10 : (dstFmt == fmtBin32) ? 23 : 52;
					if (fb > u) // Exact halfway between two targets.
						lane = (lane & ~((64'd1 << (fb - u)) - 1)) | (64'd1 << (fb - u - 1));
				end
				default: ;
			endcase
		end else if (vecPos[4]) begin
			case (flavor)
				3'd4: lane = mask; // Minus one.
				3'd5: lane = '0;
				3'd6: lane = lane | (64'd1 << (w - 1));
				3'd7: lane = 64'd1 << (w - 1); // Most negative.
				default: ;
			endcase
		end
		shift   = (vecPos[1:0] % (128 / w)) * w;
		vecData = (vecData & ~(vecT'(mask) << shift)) | (vecT'(lane) << shift);
	endtask

	initial begin
		seed       = 32'hac10f9ea;
		clock      = 1'b0;
		arstN      = 1'b0;
		inValid    = 1'b0;
		vecData    = '0;
		vecPos     = '0;
		dstFmt     = fmtBin16;
		done       = 1'b0;
		cycleCount = 0;
		repeat (4) @(negedge clock);
		arstN = 1'b1;
		repeat (stimCycles) begin
			@(negedge clock);
			driveStimulus();
		end
		@(negedge clock);
		inValid = 1'b0;
		while (pending != 0)
			@(posedge clock);
		repeat (4) @(negedge clock); // Room for a stray outValid.
		done = 1'b1;
		repeat (2) @(negedge clock);
		$display("Error counts: %0d wrong values, %0d flow errors", valueErrors, flowErrors);
		if (valueErrors + flowErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/fp2ConvertCheck.sv
/*
 Reference model and result monitor for the converter.
 Inputs are sampled on the rising edge, results compared on the falling edge.
 Results must come out in input order.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2ConvertCheck (
	input  logic         clock,
	input  logic         arstN,
	input  logic         inValid,
	input  fp2Pkg::vecT  vecData,
	input  fp2Pkg::posT  vecPos,
	input  fp2Pkg::fmtT  dstFmt,
	input  logic         outValid,
	input  fp2Pkg::elemT outData,
	input  logic         done,
	output int           valueErrors,
	output int           flowErrors,
	output int           pending
);
	import fp2Pkg::*;

	elemT  expectQ[$];
	string nameQ[$];
	int    checkCount;
	logic  doneSeen;
	logic  sampleValid;
	vecT   sampleVec;
	posT   samplePos;
	fmtT   sampleFmt;

	function automatic elemT packElem(logic sgn, logic [63:0] expField, logic [63:0] fracField,
		int dEb, int n);
		logic [63:0] expMask;

		expMask = (64'd1 << dEb) - 1;
		return (64'(sgn) << (dEb + n - 1)) | ((expField & expMask) << (n - 1)) | fracField;
	endfunction

	// Unpack to the internal form, then normalize, round and pack.
	function automatic elemT expectedElem(vecT vec, posT pos, fmtT fmt);
		int          w;
		int          eb;
		int          fb;
		int          ef;
		int          e;
		int          p;
		int          n;
		int          dEb;
		int          ue;
		logic [63:0] x;
		logic [63:0] mask;
		logic [63:0] m;
		logic        sgn;
		fracT        f;

		if (pos[3:2] == 2'd3)
			return '0; // Binary128 and reserved.
		w    = 16 << pos[3:2];
		mask = {64{1'b1}} >> (64 - w);
		x    = 64'(vec >> ((pos[1:0] % (128 / w)) * w)) & mask;
		sgn  = 1'b0;
		e    = 0;
		f    = '0;
		dEb  = (fmt == fmtBin16) ? 5 : (fmt == fmtBin32) ? 8 : 11;
		n    = (fmt == fmtBin16) ? 11 : (fmt == fmtBin32) ? 24 : 53;
		if (!pos[4] && !pos[5]) begin
			eb  = (w == 16) ? 5 : (w == 32) ? 8 : 11;
			fb  = w - 1 - eb;
			sgn = x[w - 1];
			ef  = int'(x >> fb) & ((1 << eb) - 1);
			if (ef == (1 << eb) - 1)
				return packElem(sgn, '1, ((x & (mask >> (eb + 1))) != 0) ?
					64'd1 << (n - 2) : 64'd0, dEb, n);
			if (ef != 0) begin
				f = (fracT'(1) << 70) | (fracT'(x & (mask >> (eb + 1))) << (70 - fb));
				e = ef - ((1 << (eb - 1)) - 1) + int'(expBias);
			end
		end else if (!pos[4]) begin
			f = fracT'(x) << (70 - w); // Value x / 2^w.
			e = int'(expBias);
		end else begin
			e = int'(expBias) + w;
			if (!pos[5] && x[w - 1]) begin
				sgn = 1'b1;
				x   = (~x + 64'd1) & mask; // Magnitude of the two's complement value.
			end
			f = fracT'(x) << (70 - w);
		end
		if (f == '0)
			return packElem(sgn, 64'd0, 64'd0, dEb, n);
		p = 70;
		while (!f[p])
			p--;
		f = f << (70 - p);
		e = e - (70 - p);
		m = 64'(f >> (71 - n)) + 64'(f[70 - n]); // Half up in magnitude.
		if (m[n]) begin
			m = m >> 1;
			e++;
		end
		ue = e - int'(expBias) + (1 << (dEb - 1)) - 1;
		if (ue >= (1 << dEb) - 1)
			return packElem(sgn, '1, 64'd0, dEb, n);
		if (ue <= 0)
			return packElem(sgn, 64'd0, 64'd0, dEb, n);
		return packElem(sgn, 64'(ue), m & ((64'd1 << (n - 1)) - 1), dEb, n);
	endfunction

	function automatic string caseName(posT pos, fmtT fmt);
		string kind;

		if (pos[3:2] == 2'd3)
			return $sformatf("reserved%0d->bin", pos[4:2]);
		if (pos[4])
			kind = pos[5] ? "word" : "int";
		else
			kind = pos[5] ? "fix" : "bin";
		return $sformatf("%s%0d->bin%0d", kind, 16 << pos[3:2],
			(fmt == fmtBin16) ? 16 : (fmt == fmtBin32) ? 32 : 64);
	endfunction

	initial begin
		valueErrors = 0;
		flowErrors  = 0;
		pending     = 0;
		checkCount  = 0;
		doneSeen    = 1'b0;
		sampleValid = 1'b0;
	end

	always @(posedge clock) begin
		sampleValid = inValid && arstN;
		sampleVec   = vecData;
		samplePos   = vecPos;
		sampleFmt   = dstFmt;
	end

	always @(negedge clock) begin
		if (arstN && outValid) begin
			if (expectQ.size() == 0) begin
				$display("outValid went high at %0t with no element in flight", $time);
				flowErrors++;
			end else begin
				if (outData !== expectQ[0]) begin
					$display("** Error %s #%0d: expected %h, actual %h", nameQ[0], checkCount,
						expectQ[0], outData);
					valueErrors++;
				end
				checkCount++;
				void'(expectQ.pop_front());
				void'(nameQ.pop_front());
			end
		end
		if (sampleValid) begin
			expectQ.push_back(expectedElem(sampleVec, samplePos, sampleFmt));
			nameQ.push_back(caseName(samplePos, sampleFmt));
		end
		if (done && !doneSeen) begin
			doneSeen = 1'b1;
			if (expectQ.size() != 0) begin
				$display("%0d accepted elements never came out", expectQ.size());
				flowErrors++;
			end
		end
		pending = expectQ.size();
	end

endmodule

`default_nettype wire

// File: test/fp2Convert_assert.sv
/*
 Valid timing properties, bound into fp2Convert.
 The latency property assumes no reset pulse while elements are in flight.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2ConvertAssert (
	input logic clock,
	input logic arstN,
	input logic inValid,
	input logic outValid
);

	// Three register stages from inValid to outValid.
	property latencyThree;
		@(posedge clock) disable iff (!arstN)
			$past(arstN, 3) |-> outValid == $past(inValid, 3);
	endproperty

	latencyCheck: assert property (latencyThree)
		else $error("outValid does not follow inValid by three cycles");

	resetCheck: assert property (@(posedge clock) !arstN |-> !outValid)
		else $error("outValid high while in reset");

endmodule

bind fp2Convert fp2ConvertAssert uAssert (
	.clock    (clock),
	.arstN    (arstN),
	.inValid  (inValid),
	.outValid (outValid)
);

`default_nettype wire

// File: verilog/fp2Convert.sv
/*
 Vector element converter, three cycles from inValid to outValid.
 A new element may enter every cycle. There is no back-pressure.
 outData is only meaningful in the cycle where outValid is high.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2Convert (
	input  logic         clock,
	input  logic         arstN,
	input  logic         inValid,
	input  fp2Pkg::vecT  vecData,
	input  fp2Pkg::posT  vecPos,
	input  fp2Pkg::fmtT  dstFmt,
	output logic         outValid,
	output fp2Pkg::elemT outData
);

	fp2ElemIf unpackBus ();
	fp2ElemIf normBus ();

	// Stage 1, lane select and unpack.
	fp2Unpack uUnpack (
		.clock   (clock),
		.arstN   (arstN),
		.inValid (inValid),
		.vecData (vecData),
		.vecPos  (vecPos),
		.dstFmt  (dstFmt),
		.outElem (unpackBus.src)
	);

	// Stage 2.
	fp2Normalize uNormalize (
		.clock   (clock),
		.arstN   (arstN),
		.inElem  (unpackBus.dst),
		.outElem (normBus.src)
	);

	// Stage 3, round and pack.
	fp2Pack uPack (
		.clock    (clock),
		.arstN    (arstN),
		.inElem   (normBus.dst),
		.outValid (outValid),
		.outData  (outData)
	);

endmodule

`default_nettype wire

// File: verilog/fp2Pack.sv
/*
 Round and pack into binary16, binary32 or binary64.
 Rounding is to nearest with ties away from zero, and there are no flags.
 Results below the smallest normal flush to signed zero. A NaN leaves quiet with its sign.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2Pack (
	input  logic         clock,
	input  logic         arstN,
	fp2ElemIf.dst        inElem,
	output logic         outValid,
	output fp2Pkg::elemT outData
);
	import fp2Pkg::*;

	logic [53:0]        mant;      // Hidden bit, fraction and a carry bit.
	logic               carry;
	logic signed [17:0] dstBias;
	logic signed [17:0] dstMax;    // All-ones exponent of the target.
	logic signed [17:0] newExp;
	logic [51:0]        nanBit;
	logic [10:0]        expField;
	logic [51:0]        fracField;
	elemT               packedElem;

	// Adding the first dropped bit gives ties away from zero.
	always_comb begin
		case (inElem.fmt)
			fmtBin16: begin
				mant    = 54'(inElem.frac[70:60]) + 54'(inElem.frac[59]);
				carry   = mant[11];
				dstBias = 18'sd15;
				dstMax  = 18'sd31;
				nanBit  = 52'd1 << 9;
			end
			fmtBin32: begin
				mant    = 54'(inElem.frac[70:47]) + 54'(inElem.frac[46]);
				carry   = mant[24];
				dstBias = 18'sd127;
				dstMax  = 18'sd255;
				nanBit  = 52'd1 << 22;
			end
			default: begin
				mant    = 54'(inElem.frac[70:18]) + 54'(inElem.frac[17]);
				carry   = mant[53];
				dstBias = 18'sd1023;
				dstMax  = 18'sd2047;
				nanBit  = 52'd1 << 51;
			end
		endcase

		newExp = $signed({2'b00, inElem.exp}) - $signed({2'b00, expBias}) + dstBias +
			$signed({17'd0, carry});

		// A carry out leaves all lower mantissa bits clear.
		expField  = newExp[10:0];
		fracField = mant[51:0];

		if (inElem.exp == expSpecial) begin
			expField  = '1;
			fracField = (inElem.frac[69:0] != '0) ? nanBit : '0;
		end else if (newExp >= dstMax) begin
			expField  = '1; // Overflow to infinity.
			fracField = '0;
		end else if (newExp <= 18'sd0) begin
			expField  = '0;
			fracField = '0;
		end
	end

	always_comb begin
		case (inElem.fmt)
			fmtBin16: packedElem = {48'd0, inElem.sign, expField[4:0], fracField[9:0]};
			fmtBin32: packedElem = {32'd0, inElem.sign, expField[7:0], fracField[22:0]};
			default:  packedElem = {inElem.sign, expField, fracField};
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			outValid <= 1'b0;
		else
			outValid <= inElem.valid;
	end

	always_ff @(posedge clock) begin
		if (inElem.valid)
			outData <= packedElem;
	end

endmodule

`default_nettype wire

// File: verilog/fp2Normalize.sv
/*
 Normalize so that fraction bit 70 is set.
 Bit 71 must be zero on entry. Inf and NaN pass through unshifted.
 A zero fraction leaves with exponent 0 and its sign kept.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2Normalize (
	input  logic  clock,
	input  logic  arstN,
	fp2ElemIf.dst inElem,
	fp2ElemIf.src outElem
);
	import fp2Pkg::*;

	logic [6:0] lzc;      // Leading zeros below the guard bit.
	logic       fracZero;
	expT        normExp;
	fracT       normFrac;

	// Last hit wins, so the highest set bit sets the count.
	always_comb begin
		lzc = 7'd0;
		for (int i = 0; i < 71; i++) begin
			if (inElem.frac[i])
				lzc = 7'(70 - i);
		end
	end

	assign fracZero = (inElem.frac[70:0] == '0);

	always_comb begin
		if (inElem.exp == expSpecial) begin
			normExp  = inElem.exp;
			normFrac = inElem.frac;
		end else if (fracZero) begin
			normExp  = '0;
			normFrac = '0;
		end else begin
			normExp  = inElem.exp - expT'(lzc);
			normFrac = inElem.frac << lzc;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			outElem.valid <= 1'b0;
		else
			outElem.valid <= inElem.valid;
	end

	always_ff @(posedge clock) begin
		if (inElem.valid) begin
			outElem.sign <= inElem.sign;
			outElem.exp  <= normExp;
			outElem.frac <= normFrac;
			outElem.fmt  <= inElem.fmt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fp2Unpack.sv
/*
 Lane select and unpack into sign, 16-bit exponent and 72-bit fraction.
 Subnormal floats flush to signed zero. Binary128 and reserved types give +0.
 Negative integers unpack to sign and magnitude, so the result is exact before rounding.
 */
`timescale 1ns/1ns
`default_nettype none

module fp2Unpack (
	input  logic         clock,
	input  logic         arstN,
	input  logic         inValid,
	input  fp2Pkg::vecT  vecData,
	input  fp2Pkg::posT  vecPos,
	input  fp2Pkg::fmtT  dstFmt,
	fp2ElemIf.src        outElem
);
	import fp2Pkg::*;

	logic [15:0] elem16;
	logic [31:0] elem32;
	logic [63:0] elem64;
	logic        sign;
	expT         elemExp;
	logic        hidden;
	logic [63:0] body;   // Bits 69..6 of the fraction.

	// Lane pick from the index bits.
	always_comb begin
		case (vecPos[1:0])
			2'd0: begin
				elem16 = vecData[15:0];
				elem32 = vecData[31:0];
			end
			2'd1: begin
				elem16 = vecData[31:16];
				elem32 = vecData[63:32];
			end
			2'd2: begin
				elem16 = vecData[47:32];
				elem32 = vecData[95:64];
			end
			default: begin
				elem16 = vecData[63:48];
				elem32 = vecData[127:96];
			end
		endcase
		elem64 = vecPos[0] ? vecData[127:64] : vecData[63:0]; // Only index bit 0 matters.
	end

	always_comb begin
		sign    = 1'b0;
		elemExp = '0;
		hidden  = 1'b0;
		body    = '0;

		casez (vecPos[5:2])
			4'b0000: begin
				sign = elem16[15]; // Zero exponent keeps only the sign.
				if (elem16[14:10] != 5'h00) begin
					hidden        = 1'b1;
					body[63:54]   = elem16[9:0];
					elemExp       = (elem16[14:10] == 5'h1f) ? expSpecial :
						16'(elem16[14:10]) + (expBias - 16'd15);
				end
			end
			4'b0001: begin
				sign = elem32[31];
				if (elem32[30:23] != 8'h00) begin
					hidden        = 1'b1;
					body[63:41]   = elem32[22:0];
					elemExp       = (elem32[30:23] == 8'hff) ? expSpecial :
						16'(elem32[30:23]) + (expBias - 16'd127);
				end
			end
			4'b0010: begin
				sign = elem64[63];
				if (elem64[62:52] != 11'h000) begin
					hidden        = 1'b1;
					body[63:12]   = elem64[51:0];
					elemExp       = (elem64[62:52] == 11'h7ff) ? expSpecial :
						16'(elem64[62:52]) + (expBias - 16'd1023);
				end
			end
			// Raw fractions, value is x / 2^width.
			4'b1000: begin
				body[63:48] = elem16;
				elemExp     = expBias;
			end
			4'b1001: begin
				body[63:32] = elem32;
				elemExp     = expBias;
			end
			4'b1010: begin
				body    = elem64;
				elemExp = expBias;
			end
			4'bz100: begin
				elemExp     = expBias + 16'd16;
				sign        = !vecPos[5] && elem16[15]; // Signed and negative.
				body[63:48] = sign ? -elem16 : elem16;
			end
			4'bz101: begin
				elemExp     = expBias + 16'd32;
				sign        = !vecPos[5] && elem32[31];
				body[63:32] = sign ? -elem32 : elem32;
			end
			4'bz110: begin
				elemExp = expBias + 16'd64;
				sign    = !vecPos[5] && elem64[63];
				body    = sign ? -elem64 : elem64; // Most negative keeps its magnitude.
			end
			default: begin
			end // Binary128 and reserved give +0.
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			outElem.valid <= 1'b0;
		else
			outElem.valid <= inValid;
	end

	always_ff @(posedge clock) begin
		if (inValid) begin
			outElem.sign <= sign;
			outElem.exp  <= elemExp;
			outElem.frac <= {1'b0, hidden, body, 6'd0};
			outElem.fmt  <= dstFmt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fp2ElemIf.sv
/*
 One unpacked element moving between converter stages.
 valid is a single-cycle strobe. The other fields only mean something while it is high.
 */
`timescale 1ns/1ns
`default_nettype none

interface fp2ElemIf;
	import fp2Pkg::*;

	logic valid;
	logic sign;
	expT  exp;
	fracT frac;
	fmtT  fmt; // Destination format, carried along.

	modport src (
		output valid, sign, exp, frac, fmt
	);

	modport dst (
		input valid, sign, exp, frac, fmt
	);

endinterface

`default_nettype wire

// File: verilog/fp2Pkg.sv
/*
 Shared widths and codes for the element converter.
 The internal exponent is biased by 16383. An exponent of 32767 marks Inf or NaN.
 Destination format code 3 is handled as binary64.
 */
`default_nettype none

package fp2Pkg;

	typedef logic [127:0] vecT; // Full vector register.
	typedef logic [5:0]   posT; // {ext, type[2:0], index[1:0]}.
	typedef logic [1:0]   fmtT; // Destination format code.
	typedef logic [15:0]  expT; // Internal biased exponent.

	// Bit 71 guard, bit 70 hidden, bits 5..0 fill tail.
	typedef logic [71:0]  fracT;

	typedef logic [63:0]  elemT; // Packed result, zero extended.

	localparam fmtT fmtBin16 = 2'd0;
	localparam fmtT fmtBin32 = 2'd1;
	localparam fmtT fmtBin64 = 2'd2;

	localparam expT expBias    = 16'd16383;
	localparam expT expSpecial = 16'd32767; // Inf or NaN.

endpackage

`default_nettype wire
